/* verilog/video_pkg.sv */
package video_pkg;

   // Colour channel geometry
   localparam int COMP_W = 8;
   localparam int N_CHAN = 3;

   // One colour channel value
   typedef logic [COMP_W-1:0] component_t;

   // RGB pixel, red in the top byte, blue in the bottom byte
   typedef logic [N_CHAN*COMP_W-1:0] pixel_t;

   // Inversion mask
   // bit 2 red, bit 1 green, bit 0 blue
   typedef logic [N_CHAN-1:0] chan_mask_t;

   // One pixel-clock beat of the video stream, 27 bits
   typedef struct packed {
      logic   hs;
      logic   vs;
      logic   de;
      pixel_t pixel;
   } video_beat_t;

   // Beat plus frame-start marker
   // sof is set on the beat where vs rises
   typedef struct packed {
      video_beat_t beat;
      logic        sof;
   } stage_beat_t;

   // Board status bits
   typedef struct packed {
      logic lock;
      logic frame_toggle;
   } video_status_t;

endpackage

/* verilog/video_in_stage.sv */
`timescale 1ns/1ps

module video_in_stage
   import video_pkg::*;
#(
   parameter int CNT_W = 12
) (
   input  logic             clk_i,
   input  logic             reset_i,
   input  video_beat_t      vid_i,
   output stage_beat_t      beat_o,
   output logic [CNT_W-1:0] width_o,
   output logic [CNT_W-1:0] height_o,
   output logic             lock_o
);

   // Width and height counter type
   typedef logic [CNT_W-1:0] cnt_t;

   stage_beat_t beat_r;

   logic vs_rise;
   logic de_start;
   logic de_end;

   cnt_t run_cnt;
   cnt_t last_run;
   cnt_t line_cnt;
   cnt_t new_width;
   cnt_t new_height;
   cnt_t width_r;
   cnt_t height_r;
   logic lock_r;

   // Edges of the incoming stream against the previous registered beat
   assign vs_rise  = vid_i.vs & ~beat_r.beat.vs;
   assign de_start = vid_i.de & ~beat_r.beat.de;
   assign de_end   = ~vid_i.de & beat_r.beat.de;

   // Size of the frame that ends here
   // a de run still open at the vs edge counts as the last line
   assign new_width  = beat_r.beat.de ? run_cnt : last_run;
   assign new_height = line_cnt;

   // Input register, one cycle of latency
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         beat_r <= '0;
      end else begin
         beat_r.beat <= vid_i;
         beat_r.sof  <= vs_rise;
      end
   end

   // Pixels in the current de run
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         run_cnt  <= '0;
         last_run <= '0;
      end else begin
         if (de_start) begin
            run_cnt <= cnt_t'(1);
         end else if (vid_i.de) begin
            run_cnt <= run_cnt + cnt_t'(1);
         end
         // Keep the length of the run that just closed
         if (de_end) begin
            last_run <= run_cnt;
         end
      end
   end

   // De runs in the current frame
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         line_cnt <= '0;
      end else if (vs_rise) begin
         // New frame, a run starting on the same beat is its first line
         line_cnt <= de_start ? cnt_t'(1) : '0;
      end else if (de_start) begin
         line_cnt <= line_cnt + cnt_t'(1);
      end
   end

   // Publish size at frame start, lock on two equal non-zero sizes
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         width_r  <= '0;
         height_r <= '0;
         lock_r   <= 1'b0;
      end else if (vs_rise) begin
         width_r  <= new_width;
         height_r <= new_height;
         lock_r   <= (new_width == width_r) && (new_height == height_r) &&
                     (new_width != '0) && (new_height != '0);
      end
   end

   assign beat_o   = beat_r;
   assign width_o  = width_r;
   assign height_o = height_r;
   assign lock_o   = lock_r;

endmodule

/* verilog/channel_invert.sv */
`timescale 1ns/1ps

module channel_invert
   import video_pkg::*;
(
   input  logic        clk_i,
   input  logic        reset_i,
   input  stage_beat_t beat_i,
   input  chan_mask_t  sw_i,
   output video_beat_t beat_o
);

   chan_mask_t  mask_r;
   chan_mask_t  mask_sel;
   pixel_t      pix_inv;
   video_beat_t beat_r;

   // Frame mask, taken once per frame so a frame never tears
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         mask_r <= '0;
      end else if (beat_i.sof) begin
         mask_r <= sw_i;
      end
   end

   // First beat of a frame already uses the new switch value
   assign mask_sel = beat_i.sof ? sw_i : mask_r;

   // Per-channel inversion
   // channel 2 is red in the top byte
   always_comb begin
      for (int c = 0; c < N_CHAN; c++) begin
         pix_inv[c*COMP_W +: COMP_W] = beat_i.beat.pixel[c*COMP_W +: COMP_W] ^
                                       {COMP_W{mask_sel[c]}};
      end
   end

   // Output register with syncs and enable kept in step
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         beat_r <= '0;
      end else begin
         beat_r.hs    <= beat_i.beat.hs;
         beat_r.vs    <= beat_i.beat.vs;
         beat_r.de    <= beat_i.beat.de;
         beat_r.pixel <= pix_inv;
      end
   end

   assign beat_o = beat_r;

endmodule

/* verilog/video_out_stage.sv */
`timescale 1ns/1ps

module video_out_stage
   import video_pkg::*;
(
   input  logic          clk_i,
   input  logic          reset_i,
   input  video_beat_t   beat_i,
   input  logic          lock_i,
   input  logic          sof_i,
   output video_beat_t   vid_o,
   output video_status_t status_o
);

   pixel_t blank_pix;
   logic   sof_d;

   // Pixel bits forced to zero outside the active area
   assign blank_pix = beat_i.de ? beat_i.pixel : '0;

   // Output register
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         vid_o <= '0;
      end else begin
         vid_o.hs    <= beat_i.hs;
         vid_o.vs    <= beat_i.vs;
         vid_o.de    <= beat_i.de;
         vid_o.pixel <= blank_pix;
      end
   end

   // Sof comes from the input stage
   // one register lines it up with beat_i after the inversion stage
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         sof_d <= 1'b0;
      end else begin
         sof_d <= sof_i;
      end
   end

   // Heartbeat flips as the first beat of a frame leaves
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         status_o <= '0;
      end else begin
         status_o.lock <= lock_i;
         if (sof_d) begin
            status_o.frame_toggle <= ~status_o.frame_toggle;
         end
      end
   end

endmodule

/* verilog/video_pipe_top.sv */
`timescale 1ns/1ps

module video_pipe_top
   import video_pkg::*;
#(
   parameter int CNT_W = 12
) (
   input  logic             clk_i,
   input  logic             reset_i,
   input  video_beat_t      vid_i,
   input  chan_mask_t       sw_i,
   output video_beat_t      vid_o,
   output video_status_t    status_o,
   output logic [CNT_W-1:0] active_width_o,
   output logic [CNT_W-1:0] active_height_o
);

   // Between input stage and inversion
   stage_beat_t in_beat;
   logic        in_lock;

   // Between inversion and output stage
   video_beat_t inv_beat;

   // Register, frame start and size measurement
   video_in_stage #(
      .CNT_W(CNT_W)
   ) i_video_in_stage (
      .clk_i(clk_i),
      .reset_i(reset_i),
      .vid_i(vid_i),
      .beat_o(in_beat),
      .width_o(active_width_o),
      .height_o(active_height_o),
      .lock_o(in_lock)
   );

   // Switch-selected channel inversion
   channel_invert i_channel_invert (
      .clk_i(clk_i),
      .reset_i(reset_i),
      .beat_i(in_beat),
      .sw_i(sw_i),
      .beat_o(inv_beat)
   );

   // Blanking, output register and status
   video_out_stage i_video_out_stage (
      .clk_i(clk_i),
      .reset_i(reset_i),
      .beat_i(inv_beat),
      .lock_i(in_lock),
      .sof_i(in_beat.sof),
      .vid_o(vid_o),
      .status_o(status_o)
   );

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 8
) (
   output logic clk_o,
   output logic reset_o
);

   // Free-running pixel clock
   initial begin
      clk_o = 1'b0;
      forever begin
         #(PERIOD_NS / 2) clk_o = ~clk_o;
      end
   end

   // Reset held for a fixed number of rising edges, released on a falling edge
   initial begin
      reset_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      reset_o = 1'b0;
   end

endmodule

/* verification/video_pipe_tb.sv */
`timescale 1ns/1ps

module video_pipe_tb
   import video_pkg::*;
();

   localparam int          CNT_W        = 12;
   localparam logic [31:0] RAND_SEED    = 32'h3382f9c9;
   // Whole run is about 4k cycles
   localparam int          MAX_CYCLES   = 20000;
   localparam int          RESET_CYCLES = 8;
   // Frame timing in beats
   localparam int          VS_LEN       = 2;
   localparam int          VBP          = 3;
   localparam int          HBLANK       = 16;
   localparam int          HS_LEN       = 4;
   localparam int          TAIL         = 12;
   localparam int          PIPE_DEPTH   = 3;

   typedef logic [CNT_W-1:0] size_t;

   // Driven beat and the mask in force for it
   typedef struct packed {
      video_beat_t beat;
      chan_mask_t  mask;
   } exp_entry_t;

   logic          clk_i;
   logic          reset_i;
   video_beat_t   vid_i;
   chan_mask_t    sw_i;
   video_beat_t   vid_o;
   video_status_t status_o;
   size_t         active_width_o;
   size_t         active_height_o;

   // Frame-level model
   size_t pub_w;
   size_t pub_h;
   size_t last_w;
   size_t last_h;
   logic  exp_lock;
   logic  exp_toggle;

   exp_entry_t beat_q[$];

   int err_video;
   int err_size;
   int err_status;
   int cycle_cnt;

   tb_clock_gen #(
      .PERIOD_NS(8),
      .RESET_CYCLES(RESET_CYCLES)
   ) i_clock_gen (
      .clk_o(clk_i),
      .reset_o(reset_i)
   );

   video_pipe_top #(
      .CNT_W(CNT_W)
   ) i_dut (
      .clk_i(clk_i),
      .reset_i(reset_i),
      .vid_i(vid_i),
      .sw_i(sw_i),
      .vid_o(vid_o),
      .status_o(status_o),
      .active_width_o(active_width_o),
      .active_height_o(active_height_o)
   );

   // Output pixel rule with masked channels inverted and blanking outside de
   function automatic video_beat_t expected_beat(input video_beat_t in_beat,
                                                 input chan_mask_t  mask);
      video_beat_t res;
      component_t  red;
      component_t  green;
      component_t  blue;
      res   = in_beat;
      red   = in_beat.pixel[23:16];
      green = in_beat.pixel[15:8];
      blue  = in_beat.pixel[7:0];
      if (mask[2]) red   = ~red;
      if (mask[1]) green = ~green;
      if (mask[0]) blue  = ~blue;
      res.pixel = in_beat.de ? {red, green, blue} : '0;
      return res;
   endfunction

   task automatic check_output_beat(input video_beat_t exp);
      assert (vid_o.hs == exp.hs) else begin
         $display("Mismatch vid_o.hs at %0t: got %h expected %h", $time, vid_o.hs, exp.hs);
         err_video++;
      end
      assert (vid_o.vs == exp.vs) else begin
         $display("Mismatch vid_o.vs at %0t: got %h expected %h", $time, vid_o.vs, exp.vs);
         err_video++;
      end
      assert (vid_o.de == exp.de) else begin
         $display("Mismatch vid_o.de at %0t: got %h expected %h", $time, vid_o.de, exp.de);
         err_video++;
      end
      assert (vid_o.pixel == exp.pixel) else begin
         $display("Mismatch vid_o.pixel at %0t: got %h expected %h",
                  $time, vid_o.pixel, exp.pixel);
         err_video++;
      end
   endtask

   // Sampled just before a vs edge or once the last edge has settled
   task automatic check_frame_status();
      assert (active_width_o == pub_w) else begin
         $display("Mismatch active_width_o: got %h expected %h", active_width_o, pub_w);
         err_size++;
      end
      assert (active_height_o == pub_h) else begin
         $display("Mismatch active_height_o: got %h expected %h", active_height_o, pub_h);
         err_size++;
      end
      assert (status_o.lock == exp_lock) else begin
         $display("Mismatch status_o.lock: got %h expected %h", status_o.lock, exp_lock);
         err_status++;
      end
      assert (status_o.frame_toggle == exp_toggle) else begin
         $display("Mismatch status_o.frame_toggle: got %h expected %h",
                  status_o.frame_toggle, exp_toggle);
         err_status++;
      end
   endtask

   // Vs edge publishes the frame just generated
   task automatic advance_frame_model();
      exp_lock   = (last_w == pub_w) && (last_h == pub_h) &&
                   (last_w != '0) && (last_h != '0);
      pub_w      = last_w;
      pub_h      = last_h;
      exp_toggle = ~exp_toggle;
   endtask

   // Called on a falling edge and returns on the next one
   task automatic drive_beat(input logic hs, input logic vs, input logic de);
      logic [31:0] rnd;
      rnd         = $urandom();
      vid_i.hs    = hs;
      vid_i.vs    = vs;
      vid_i.de    = de;
      vid_i.pixel = rnd[23:0];
      @(negedge clk_i);
   endtask

   task automatic send_vs_pulse();
      check_frame_status();
      advance_frame_model();
      repeat (VS_LEN) drive_beat(1'b0, 1'b1, 1'b0);
      repeat (VBP) drive_beat(1'b0, 1'b0, 1'b0);
   endtask

   // Switches move to next_mask halfway down the frame
   task automatic send_frame(input int w, input int h, input chan_mask_t next_mask);
      send_vs_pulse();
      for (int line = 0; line < h; line++) begin
         if (line == h / 2) sw_i = next_mask;
         for (int x = 0; x < w; x++) begin
            drive_beat(1'b0, 1'b0, 1'b1);
         end
         // Random pixel data stays on the bus during blanking
         for (int x = 0; x < HBLANK; x++) begin
            drive_beat(x < HS_LEN, 1'b0, 1'b0);
         end
      end
      last_w = size_t'(w);
      last_h = size_t'(h);
   endtask

   task automatic report_counts();
      $display("Errors: video=%0d size=%0d status=%0d total=%0d",
               err_video, err_size, err_status, err_video + err_size + err_status);
   endtask

   // Inputs captured on the rising edge and outputs checked on the falling edge
   initial begin : compare_beats
      exp_entry_t entry;
      chan_mask_t frame_mask;
      logic       prev_vs;
      frame_mask = '0;
      prev_vs    = 1'b0;
      @(negedge reset_i);
      forever begin
         @(posedge clk_i);
         // Mask taken on the vs rising beat
         if (vid_i.vs && !prev_vs) frame_mask = sw_i;
         prev_vs    = vid_i.vs;
         entry.beat = vid_i;
         entry.mask = frame_mask;
         beat_q.push_back(entry);
         @(negedge clk_i);
         if (beat_q.size() == PIPE_DEPTH) begin
            entry = beat_q.pop_front();
            check_output_beat(expected_beat(entry.beat, entry.mask));
         end else begin
            // Pipeline still filling from reset
            assert (vid_o == '0) else begin
               $display("Mismatch vid_o after reset: got %h expected %h", vid_o, 27'h0);
               err_video++;
            end
            assert (status_o == '0) else begin
               $display("Mismatch status_o after reset: got %h expected %h", status_o, 2'h0);
               err_status++;
            end
         end
      end
   end

   initial begin : watchdog
      cycle_cnt = 0;
      while (cycle_cnt < MAX_CYCLES) begin
         @(posedge clk_i);
         cycle_cnt++;
      end
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      report_counts();
      $display("STATUS: FAIL");
      $finish;
   end

   initial begin : stimulus
      logic [31:0] rnd;
      void'($urandom(RAND_SEED));
      vid_i      = '0;
      sw_i       = '0;
      pub_w      = '0;
      pub_h      = '0;
      last_w     = '0;
      last_h     = '0;
      exp_lock   = 1'b0;
      exp_toggle = 1'b0;
      err_video  = 0;
      err_size   = 0;
      err_status = 0;
      // Random syncs, enable and pixels while reset is held
      // reset alone keeps them away from the outputs and the size counters
      repeat (RESET_CYCLES - 1) begin
         @(negedge clk_i);
         rnd   = $urandom();
         vid_i = rnd[26:0];
      end
      @(negedge reset_i);
      vid_i = '0;
      @(negedge clk_i);
      // Idle blanking before the first frame
      repeat (6) drive_beat(1'b0, 1'b0, 1'b0);
      // 64x8 then 40x6 while the mask steps through all eight values
      for (int f = 0; f < 8; f++) begin
         if (f < 4) begin
            send_frame(64, 8, chan_mask_t'(f + 1));
         end else begin
            send_frame(40, 6, chan_mask_t'(f + 1));
         end
      end
      // Closing edge publishes the last frame
      send_vs_pulse();
      repeat (TAIL) drive_beat(1'b0, 1'b0, 1'b0);
      check_frame_status();
      report_counts();
      if (err_video + err_size + err_status == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

/* filelist.f */
verilog/video_pkg.sv
verilog/video_in_stage.sv
verilog/channel_invert.sv
verilog/video_out_stage.sv
verilog/video_pipe_top.sv
verification/tb_clock_gen.sv
verification/video_pipe_tb.sv

/* Makefile */
# Verilator build and run of the video pipeline testbench
# Any variable can be set on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= video_pipe_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: sim clean

# Build, run, then scan the log for the failure status line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	$(SIM_BIN) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "STATUS: FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
		echo "Simulator exited with status $$status"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
